/* common/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // Datapath width and byte strobes per word
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // ------------------------------------------------------------------------
    // Operation encodings
    // ------------------------------------------------------------------------

    // Load kinds follow funct3
    // 3'b111 is not a RV32I load and marks "no load"
    typedef enum logic [2:0] {
        LOAD_LB   = 3'b000,
        LOAD_LH   = 3'b001,
        LOAD_LW   = 3'b010,
        LOAD_LBU  = 3'b100,
        LOAD_LHU  = 3'b101,
        LOAD_NONE = 3'b111
    } load_op_e;

    // Store kinds follow funct3 as well, 2'b11 marks "no store"
    typedef enum logic [1:0] {
        STORE_SB   = 2'b00,
        STORE_SH   = 2'b01,
        STORE_SW   = 2'b10,
        STORE_NONE = 2'b11
    } store_op_e;

    // One memory word
    // Byte view for strobes and LB/LBU, halfword view for SH and LH/LHU
    typedef union packed {
        logic [STRB_W-1:0][7:0]    bytes;
        logic [STRB_W/2-1:0][15:0] halves;
    } mem_word_u;

endpackage

`default_nettype wire

/* common/axi_lite_pkg.sv */
`default_nettype none

package axi_lite_pkg;

    // Byte address width on the AR and AW channels
    localparam int ADDR_W = 32;

    // Response codes
    // EXOKAY and DECERR never show up on this bus
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* logic/lsu_issue.sv */
`default_nettype none

module lsu_issue
    import lsu_pkg::*;
    import axi_lite_pkg::*;
(
    input  logic              M_AXI_ACLK,
    input  logic              M_AXI_ARESETN,
    // Pipeline request
    input  logic              i_pre_valid,
    input  load_op_e          i_load_op,
    input  store_op_e         i_store_op,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [DATA_W-1:0] i_store_data,
    input  logic              i_done,
    output logic              o_ready,
    // Side info for the writeback
    output logic              o_pass_valid,
    output load_op_e          o_load_op,
    output logic [1:0]        o_lane,
    // AXI4-Lite master request channels
    output logic              o_awvalid,
    output logic [ADDR_W-1:0] o_awaddr,
    input  logic              i_awready,
    output logic              o_wvalid,
    output logic [DATA_W-1:0] o_wdata,
    output logic [STRB_W-1:0] o_wstrb,
    input  logic              i_wready,
    output logic              o_arvalid,
    output logic [ADDR_W-1:0] o_araddr,
    input  logic              i_arready
);

    logic              busy;
    logic              accept;
    logic              is_load;
    logic              is_store;
    logic [ADDR_W-1:0] addr_q;
    mem_word_u         st_word;
    logic [STRB_W-1:0] st_strb;

    // One request in flight, new work only while idle
    assign o_ready  = !busy;
    assign accept   = i_pre_valid && o_ready;
    // Load wins if a request ever carries both kinds
    assign is_load  = i_load_op != LOAD_NONE;
    assign is_store = (i_store_op != STORE_NONE) && !is_load;

    // Same address feeds both address channels
    assign o_awaddr = addr_q;
    assign o_araddr = addr_q;

    // ------------------------------------------------------------------------
    // Store lane placement and strobes
    // ------------------------------------------------------------------------
    always_comb
    begin
        st_word = '0;
        st_strb = '0;
        case (i_store_op)
            STORE_SB:
            begin
                st_word.bytes[i_addr[1:0]] = i_store_data[7:0];
                st_strb[i_addr[1:0]]       = 1'b1;
            end
            STORE_SH:
            begin
                // Aligned halfword sits in lanes 0-1 or 2-3
                st_word.halves[i_addr[1]]     = i_store_data[15:0];
                st_strb[{i_addr[1], 1'b0}+:2] = 2'b11;
            end
            STORE_SW:
            begin
                st_word.bytes = i_store_data;
                st_strb       = '1;
            end
            default: ;
        endcase
    end

    // ------------------------------------------------------------------------
    // Busy state and channel valids
    // ------------------------------------------------------------------------
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            busy         <= 1'b0;
            o_pass_valid <= 1'b0;
            o_arvalid    <= 1'b0;
            o_awvalid    <= 1'b0;
            o_wvalid     <= 1'b0;
        end
        else
        begin
            if (accept)
                busy <= 1'b1;
            else if (i_done)
                busy <= 1'b0;
            // Nothing to send on the bus, writeback completes it directly
            o_pass_valid <= accept && !is_load && !is_store;
            // Each valid holds until its own ready is seen
            if (accept && is_load)
                o_arvalid <= 1'b1;
            else if (i_arready)
                o_arvalid <= 1'b0;
            // AW and W go up together and drop on their own
            if (accept && is_store)
                o_awvalid <= 1'b1;
            else if (i_awready)
                o_awvalid <= 1'b0;
            if (accept && is_store)
                o_wvalid <= 1'b1;
            else if (i_wready)
                o_wvalid <= 1'b0;
        end
    end

    // Request payload, held stable for the whole transaction
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (accept)
        begin
            addr_q    <= i_addr;
            o_wdata   <= st_word;
            o_wstrb   <= st_strb;
            o_load_op <= i_load_op;
            o_lane    <= i_addr[1:0];
        end
    end

endmodule

`default_nettype wire

/* sram/lsu_sram.sv */
`default_nettype none

module lsu_sram
    import lsu_pkg::*;
    import axi_lite_pkg::*;
#(
    parameter int MEM_WORDS = 256
)
(
    input  logic              M_AXI_ACLK,
    input  logic              M_AXI_ARESETN,
    // Write address and data
    input  logic              i_awvalid,
    input  logic [ADDR_W-1:0] i_awaddr,
    output logic              o_awready,
    input  logic              i_wvalid,
    input  logic [DATA_W-1:0] i_wdata,
    input  logic [STRB_W-1:0] i_wstrb,
    output logic              o_wready,
    // Write response
    output logic              o_bvalid,
    output logic [1:0]        o_bresp,
    input  logic              i_bready,
    // Read address and data
    input  logic              i_arvalid,
    input  logic [ADDR_W-1:0] i_araddr,
    output logic              o_arready,
    output logic              o_rvalid,
    output logic [DATA_W-1:0] o_rdata,
    output logic [1:0]        o_rresp,
    input  logic              i_rready
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    // Word addresses at or past this limit answer SLVERR
    localparam logic [ADDR_W-3:0] WORD_LIMIT = (ADDR_W-2)'(MEM_WORDS);

    mem_word_u         mem [MEM_WORDS];
    logic              aw_held, w_held;
    logic [ADDR_W-1:0] aw_addr_q, wr_addr;
    mem_word_u         w_data_q, wr_data;
    logic [STRB_W-1:0] w_strb_q, wr_strb;
    logic              aw_hs, w_hs, ar_hs;
    logic              wr_fire, wr_ok, rd_ok;

    // Not ready while a response is pending or that half of a write is parked
    assign o_awready = !aw_held && !o_bvalid;
    assign o_wready  = !w_held && !o_bvalid;
    assign o_arready = !o_rvalid;
    assign aw_hs     = i_awvalid && o_awready;
    assign w_hs      = i_wvalid && o_wready;
    assign ar_hs     = i_arvalid && o_arready;

    // Parked half or the one arriving now
    assign wr_addr = aw_held ? aw_addr_q : i_awaddr;
    assign wr_data = w_held ? w_data_q : mem_word_u'(i_wdata);
    assign wr_strb = w_held ? w_strb_q : i_wstrb;
    assign wr_fire = (aw_held || aw_hs) && (w_held || w_hs);
    assign wr_ok   = wr_addr[ADDR_W-1:2] < WORD_LIMIT;
    assign rd_ok   = i_araddr[ADDR_W-1:2] < WORD_LIMIT;

    // ------------------------------------------------------------------------
    // Handshake state
    // ------------------------------------------------------------------------
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
            o_bvalid <= 1'b0;
            o_rvalid <= 1'b0;
        end
        else
        begin
            // AW and W may come in either order
            aw_held <= !wr_fire && (aw_held || aw_hs);
            w_held  <= !wr_fire && (w_held || w_hs);
            if (wr_fire)
                o_bvalid <= 1'b1;
            else if (i_bready)
                o_bvalid <= 1'b0;
            if (ar_hs)
                o_rvalid <= 1'b1;
            else if (i_rready)
                o_rvalid <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // Array, parked write halves and responses
    // ------------------------------------------------------------------------
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (aw_hs)
            aw_addr_q <= i_awaddr;
        if (w_hs)
        begin
            w_data_q <= i_wdata;
            w_strb_q <= i_wstrb;
        end
        // Out of range write leaves the array alone
        if (wr_fire)
            o_bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        for (int b = 0; b < STRB_W; b++)
        begin
            if (wr_fire && wr_ok && wr_strb[b])
                mem[wr_addr[IDX_W+1:2]].bytes[b] <= wr_data.bytes[b];
        end
        // Out of range read returns zero
        if (ar_hs)
        begin
            o_rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
            o_rdata <= rd_ok ? mem[i_araddr[IDX_W+1:2]] : '0;
        end
    end

endmodule

`default_nettype wire

/* logic/lsu_writeback.sv */
`default_nettype none

module lsu_writeback
    import lsu_pkg::*;
    import axi_lite_pkg::*;
(
    input  logic              M_AXI_ACLK,
    input  logic              M_AXI_ARESETN,
    // Read data and write response channels
    input  logic              i_rvalid,
    input  logic [DATA_W-1:0] i_rdata,
    input  logic [1:0]        i_rresp,
    output logic              o_rready,
    input  logic              i_bvalid,
    input  logic [1:0]        i_bresp,
    output logic              o_bready,
    // From the issue block
    input  logic              i_pass_valid,
    input  load_op_e          i_load_op,
    input  logic [1:0]        i_lane,
    // Result to the pipeline
    output logic              o_post_valid,
    output logic [DATA_W-1:0] o_lsu_res,
    output logic              o_bus_err,
    output logic              o_done
);

    mem_word_u         rdata_q;
    logic [1:0]        rresp_q;
    logic              r_hs, b_hs, r_err, b_err;
    logic [7:0]        byte_sel;
    logic [15:0]       half_sel;
    logic [DATA_W-1:0] load_ext;

    assign r_hs  = i_rvalid && o_rready;
    assign b_hs  = i_bvalid && o_bready;
    assign r_err = rresp_q != RESP_OKAY;
    assign b_err = i_bresp != RESP_OKAY;
    // Completion also frees the issue side
    assign o_done = o_post_valid;

    // ------------------------------------------------------------------------
    // Lane select and extension
    // ------------------------------------------------------------------------
    always_comb
    begin
        byte_sel = rdata_q.bytes[i_lane];
        half_sel = rdata_q.halves[i_lane[1]];
        case (i_load_op)
            LOAD_LB:  load_ext = {{(DATA_W-8){byte_sel[7]}}, byte_sel};
            LOAD_LH:  load_ext = {{(DATA_W-16){half_sel[15]}}, half_sel};
            LOAD_LW:  load_ext = rdata_q;
            LOAD_LBU: load_ext = {{(DATA_W-8){1'b0}}, byte_sel};
            LOAD_LHU: load_ext = {{(DATA_W-16){1'b0}}, half_sel};
            default:  load_ext = '0;
        endcase
    end

    // Ready pulses for one cycle once valid is seen
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (!M_AXI_ARESETN)
        begin
            o_rready     <= 1'b0;
            o_bready     <= 1'b0;
            o_post_valid <= 1'b0;
            o_bus_err    <= 1'b0;
        end
        else
        begin
            o_rready     <= i_rvalid && !o_rready;
            o_bready     <= i_bvalid && !o_bready;
            o_post_valid <= r_hs || b_hs || i_pass_valid;
            o_bus_err    <= (r_hs && r_err) || (b_hs && b_err);
        end
    end

    // Read word is captured on the edge that raises rready
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (i_rvalid && !o_rready)
        begin
            rdata_q <= i_rdata;
            rresp_q <= i_rresp;
        end
        // Stores, errors and pass-through all report zero
        o_lsu_res <= (r_hs && !r_err) ? load_ext : '0;
    end

endmodule

`default_nettype wire

/* logic/lsu_top.sv */
`default_nettype none

module lsu_top
    import lsu_pkg::*;
    import axi_lite_pkg::*;
#(
    parameter int MEM_WORDS = 256
)
(
    input  logic              M_AXI_ACLK,
    input  logic              M_AXI_ARESETN,
    input  logic              i_pre_valid,
    input  load_op_e          i_load_op,
    input  store_op_e         i_store_op,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [DATA_W-1:0] i_store_data,
    output logic              o_ready,
    output logic              o_post_valid,
    output logic [DATA_W-1:0] o_lsu_res,
    output logic              o_bus_err
);

    // AXI4-Lite bus between master halves and the memory
    logic              awvalid, awready, wvalid, wready, arvalid, arready;
    logic              bvalid, bready, rvalid, rready;
    logic [ADDR_W-1:0] awaddr, araddr;
    logic [DATA_W-1:0] wdata, rdata;
    logic [STRB_W-1:0] wstrb;
    logic [1:0]        bresp, rresp;
    // Sideband from issue to writeback and back
    logic              pass_valid, done;
    load_op_e          load_op;
    logic [1:0]        lane;

    // ------------------------------------------------------------------------
    // Request issue, data memory, response writeback
    // ------------------------------------------------------------------------
    lsu_issue u_issue (
        .M_AXI_ACLK(M_AXI_ACLK), .M_AXI_ARESETN(M_AXI_ARESETN),
        .i_pre_valid(i_pre_valid), .i_load_op(i_load_op), .i_store_op(i_store_op),
        .i_addr(i_addr), .i_store_data(i_store_data), .i_done(done), .o_ready(o_ready),
        .o_pass_valid(pass_valid), .o_load_op(load_op), .o_lane(lane),
        .o_awvalid(awvalid), .o_awaddr(awaddr), .i_awready(awready),
        .o_wvalid(wvalid), .o_wdata(wdata), .o_wstrb(wstrb), .i_wready(wready),
        .o_arvalid(arvalid), .o_araddr(araddr), .i_arready(arready)
    );

    lsu_sram #(.MEM_WORDS(MEM_WORDS)) u_sram (
        .M_AXI_ACLK(M_AXI_ACLK), .M_AXI_ARESETN(M_AXI_ARESETN),
        .i_awvalid(awvalid), .i_awaddr(awaddr), .o_awready(awready),
        .i_wvalid(wvalid), .i_wdata(wdata), .i_wstrb(wstrb), .o_wready(wready),
        .o_bvalid(bvalid), .o_bresp(bresp), .i_bready(bready),
        .i_arvalid(arvalid), .i_araddr(araddr), .o_arready(arready),
        .o_rvalid(rvalid), .o_rdata(rdata), .o_rresp(rresp), .i_rready(rready)
    );

    lsu_writeback u_writeback (
        .M_AXI_ACLK(M_AXI_ACLK), .M_AXI_ARESETN(M_AXI_ARESETN),
        .i_rvalid(rvalid), .i_rdata(rdata), .i_rresp(rresp), .o_rready(rready),
        .i_bvalid(bvalid), .i_bresp(bresp), .o_bready(bready),
        .i_pass_valid(pass_valid), .i_load_op(load_op), .i_lane(lane),
        .o_post_valid(o_post_valid), .o_lsu_res(o_lsu_res), .o_bus_err(o_bus_err),
        .o_done(done)
    );

endmodule

`default_nettype wire

/* dv/lsu_tb.sv */
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
    import axi_lite_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS = 256;
    // Cycle limit for every wait loop
    localparam int TIMEOUT = 64;
    // Request kinds as they appear in the stimulus file
    localparam string KIND_LOAD  = "load";
    localparam string KIND_STORE = "store";
    localparam string KIND_OTHER = "other";

    logic              M_AXI_ACLK;
    logic              M_AXI_ARESETN;
    logic              pre_valid;
    load_op_e          load_op;
    store_op_e         store_op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] store_data;
    logic              ready;
    logic              post_valid;
    logic [DATA_W-1:0] lsu_res;
    logic              bus_err;

    int   value_errs = 0;
    int   flow_errs  = 0;
    int   timeouts   = 0;
    int   post_count = 0;
    int   req_count  = 0;
    logic timed_out  = 1'b0;

    lsu_top #(.MEM_WORDS(MEM_WORDS)) UUT (
        .M_AXI_ACLK(M_AXI_ACLK), .M_AXI_ARESETN(M_AXI_ARESETN),
        .i_pre_valid(pre_valid), .i_load_op(load_op), .i_store_op(store_op),
        .i_addr(addr), .i_store_data(store_data), .o_ready(ready),
        .o_post_valid(post_valid), .o_lsu_res(lsu_res), .o_bus_err(bus_err)
    );

    // 100 ns clock
    initial M_AXI_ACLK = 1'b0;
    always #50 M_AXI_ACLK = ~M_AXI_ACLK;

    // Every result pulse counted once on the falling edge
    always @(negedge M_AXI_ACLK)
    begin
        if (M_AXI_ARESETN && post_valid)
            post_count++;
    end

    // ------------------------------------------------------------------------
    // Request handshake helpers
    // ------------------------------------------------------------------------
    task automatic wait_until_ready();
        int cycles;
        cycles = 0;
        while (!ready && cycles < TIMEOUT)
        begin
            @(negedge M_AXI_ACLK);
            cycles++;
        end
        if (!ready)
        begin
            $display("Timed out waiting for o_ready before request %0d", req_count);
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    // Hold the request through one accepting rising edge
    task automatic drive_request(input string kind, input logic [31:0] op,
                                 input logic [31:0] a, input logic [31:0] d);
        pre_valid  = 1'b1;
        load_op    = LOAD_NONE;
        store_op   = STORE_NONE;
        if (kind == KIND_LOAD)
            load_op = load_op_e'(op[2:0]);
        else if (kind == KIND_STORE)
            store_op = store_op_e'(op[1:0]);
        addr       = a;
        store_data = d;
        @(posedge M_AXI_ACLK);
        @(negedge M_AXI_ACLK);
        pre_valid  = 1'b0;
        load_op    = LOAD_NONE;
        store_op   = STORE_NONE;
    endtask

    // Latency counts rising edges after the accepting one
    task automatic wait_for_result(output int latency);
        latency = 0;
        while (!post_valid && latency < TIMEOUT)
        begin
            // Busy until the result shows up
            if (ready)
            begin
                $display("o_ready went high before the result of request %0d", req_count);
                flow_errs++;
            end
            @(negedge M_AXI_ACLK);
            latency++;
        end
        if (!post_valid)
        begin
            $display("Timed out waiting for o_post_valid on request %0d", req_count);
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    task automatic check_result(input string kind, input logic [31:0] exp_res,
                                input logic [31:0] exp_err, input int latency);
        if (lsu_res !== exp_res)
        begin
            $display("ERR o_lsu_res req %0d expected %h got %h", req_count, exp_res, lsu_res);
            value_errs++;
        end
        if (bus_err !== exp_err[0])
        begin
            $display("ERR o_bus_err req %0d expected %h got %h", req_count, exp_err[0], bus_err);
            value_errs++;
        end
        if (ready)
        begin
            $display("o_ready was high in the result cycle of request %0d", req_count);
            flow_errs++;
        end
        // Pass-through finishes on the very next edge
        if (kind == KIND_OTHER && latency != 1)
        begin
            $display("Pass-through request %0d took %0d cycles instead of one",
                     req_count, latency);
            flow_errs++;
        end
        @(negedge M_AXI_ACLK);
        if (post_valid)
        begin
            $display("o_post_valid stayed high after request %0d", req_count);
            flow_errs++;
        end
        if (!ready)
        begin
            $display("o_ready did not come back after request %0d", req_count);
            flow_errs++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial
    begin
        int                fd;
        int                got;
        int                n;
        int                latency;
        int unsigned       gap;
        string             line_buf;
        string             kind;
        logic [31:0]       op, a, d, exp_res, exp_err;

        void'($urandom(99));
        pre_valid     = 1'b0;
        load_op       = LOAD_NONE;
        store_op      = STORE_NONE;
        addr          = '0;
        store_data    = '0;
        M_AXI_ARESETN = 1'b0;
        repeat (16) @(negedge M_AXI_ACLK);
        M_AXI_ARESETN = 1'b1;
        @(negedge M_AXI_ACLK);

        fd = $fopen("dv/lsu_input.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file dv/lsu_input.txt");
            flow_errs++;
        end
        while (fd != 0 && !timed_out && !$feof(fd))
        begin
            got = $fgets(line_buf, fd);
            // Comment and blank lines fail the full scan
            n = $sscanf(line_buf, "%s %h %h %h %h %h", kind, op, a, d, exp_res, exp_err);
            if (got != 0 && n == 6)
            begin
                req_count++;
                if (kind != KIND_LOAD && kind != KIND_STORE && kind != KIND_OTHER)
                begin
                    $display("Unknown request kind %0s on request %0d", kind, req_count);
                    flow_errs++;
                end
                wait_until_ready();
                if (!timed_out)
                begin
                    drive_request(kind, op, a, d);
                    wait_for_result(latency);
                end
                if (!timed_out)
                begin
                    check_result(kind, exp_res, exp_err, latency);
                    gap = $urandom % 4;
                    repeat (gap) @(negedge M_AXI_ACLK);
                end
            end
        end
        if (fd != 0)
            $fclose(fd);

        if (req_count == 0)
        begin
            $display("No requests were read from the stimulus file");
            flow_errs++;
        end
        if (!timed_out && post_count != req_count)
        begin
            $display("Saw %0d result pulses for %0d requests", post_count, req_count);
            flow_errs++;
        end

        $display("Requests %0d, value errors %0d, flow errors %0d, timeouts %0d",
                 req_count, value_errs, flow_errs, timeouts);
        if (value_errs == 0 && flow_errs == 0 && timeouts == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* lsu_top.f */
common/lsu_pkg.sv
common/axi_lite_pkg.sv
logic/lsu_issue.sv
sram/lsu_sram.sv
logic/lsu_writeback.sv
logic/lsu_top.sv
dv/lsu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the LSU testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module lsu_tb \
    -Mdir obj_dir -f lsu_top.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/Vlsu_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

# The testbench prints the pass line only when every check held
if grep -qxF '** PASS **' <<< "$sim_out"; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1

/* dv/lsu_input.txt */
# kind op addr store_data exp_result exp_err (all hex except kind)
# op for loads: 0=LB 1=LH 2=LW 4=LBU 5=LHU, op for stores: 0=SB 1=SH 2=SW
store 2 00000000 A5A5A5A5 00000000 0
store 2 00000010 DEADBEEF 00000000 0
load  2 00000010 00000000 DEADBEEF 0
other 0 00000000 00000000 00000000 0
store 2 00000020 11223344 00000000 0
store 0 00000021 123456AA 00000000 0
store 1 00000022 5555BEEF 00000000 0
load  2 00000020 00000000 BEEFAA44 0
store 2 00000030 80F17F92 00000000 0
load  0 00000030 00000000 FFFFFF92 0
load  4 00000030 00000000 00000092 0
load  0 00000031 00000000 0000007F 0
load  0 00000032 00000000 FFFFFFF1 0
load  4 00000033 00000000 00000080 0
load  1 00000032 00000000 FFFF80F1 0
load  5 00000032 00000000 000080F1 0
load  1 00000030 00000000 00007F92 0
other 0 00000044 FFFFFFFF 00000000 0
store 2 00000400 CAFEF00D 00000000 1
load  2 00000000 00000000 A5A5A5A5 0
load  2 00000404 00000000 00000000 1
load  0 0000FFFC 00000000 00000000 1
